/* rv_decode_defs.svh */
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// datapath and address width
`define XLEN 32

// register file index width
`define REG_ADDR_W 5

// one mask bit per byte lane
`define WMASK_W 4

// full instruction word, no other system encoding is decoded
`define INST_EBREAK 32'h0010_0073

// link address step for jal and jalr
`define PC_STEP 32'd4

// execute unit compare results
`define EXU_LT 32'd4
`define EXU_EQ 32'd0

`endif

/* rv_decode_pkg.sv */
`include "rv_decode_defs.svh"

package rv_decode_pkg;

	typedef enum logic [3:0] {
		cls_op_imm,
		cls_op_reg,
		cls_load,
		cls_store,
		cls_branch,
		cls_jal,
		cls_jalr,
		cls_lui,
		cls_auipc,
		cls_ebreak,
		cls_illegal
	} inst_class_e;

	typedef enum logic [2:0] {
		fmt_none,
		fmt_i,
		fmt_u,
		fmt_s,
		fmt_b,
		fmt_j,
		fmt_shamt
	} imm_fmt_e;

	// second operand of the execute unit
	typedef enum logic {
		src_reg,
		src_imm
	} alu_src_e;

	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_ucmp,
		op_scmp,
		op_srl,
		op_sra,
		op_sll,
		op_xor,
		op_and,
		op_or
	} alu_op_e;

	typedef struct packed {
		alu_src_e src;
		alu_op_e  op;
	} alu_ctrl_t;

	typedef enum logic [1:0] {
		rsize_byte = 2'd0,
		rsize_half = 2'd1,
		rsize_word = 2'd2
	} rsize_e;

	typedef struct packed {
		inst_class_e            cls;
		imm_fmt_e               fmt;
		logic [2:0]             funct3;
		logic                   f7_b5;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic                   unsigned_ld;
		logic                   cmp_unsigned;
	} dec_t;

	typedef struct packed {
		logic                   wen;
		logic [`REG_ADDR_W-1:0] waddr;
		logic [`XLEN-1:0]       wdata;
	} gpr_wr_t;

	typedef struct packed {
		logic             wen;
		logic [`XLEN-1:0] wdata;
	} pc_wr_t;

	typedef struct packed {
		logic                rvalid;
		logic                wen;
		logic [`XLEN-1:0]    raddr;
		logic [`XLEN-1:0]    waddr;
		logic [`XLEN-1:0]    wdata;
		logic [`WMASK_W-1:0] wmask;
		rsize_e              rsize;
	} mem_req_t;

endpackage

/* inst_dec.sv */
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module inst_dec (
	input  logic [`XLEN-1:0]    inst,
	output rv_decode_pkg::dec_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		dec.funct3       = funct3;
		dec.f7_b5        = funct7[5];
		dec.rd           = inst[11:7];
		dec.rs1          = inst[19:15];
		dec.rs2          = inst[24:20];
		dec.unsigned_ld  = funct3[2];
		// only blt and bge compare signed
		dec.cmp_unsigned = (funct3[2:1] != 2'b10);
		dec.cls          = rv_decode_pkg::cls_illegal;
		dec.fmt          = rv_decode_pkg::fmt_none;

		casez ({funct7, funct3, opcode})
			// shifts first, they overlap the generic immediate rows
			17'b0000000_001_0010011, 17'b0000000_101_0010011, 17'b010000?_101_0010011: begin
				dec.cls = rv_decode_pkg::cls_op_imm;
				dec.fmt = rv_decode_pkg::fmt_shamt;
			end
			17'b???????_000_0010011, 17'b???????_01?_0010011,
			17'b???????_100_0010011, 17'b???????_11?_0010011: begin
				dec.cls = rv_decode_pkg::cls_op_imm;
				dec.fmt = rv_decode_pkg::fmt_i;
			end
			17'b0000000_???_0110011, 17'b0100000_000_0110011, 17'b0100000_101_0110011: begin
				dec.cls = rv_decode_pkg::cls_op_reg;
			end
			17'b???????_00?_0000011, 17'b???????_010_0000011, 17'b???????_10?_0000011: begin
				dec.cls = rv_decode_pkg::cls_load;
				dec.fmt = rv_decode_pkg::fmt_i;
			end
			17'b???????_00?_0100011, 17'b???????_010_0100011: begin
				dec.cls = rv_decode_pkg::cls_store;
				dec.fmt = rv_decode_pkg::fmt_s;
			end
			17'b???????_00?_1100011, 17'b???????_1??_1100011: begin
				dec.cls = rv_decode_pkg::cls_branch;
				dec.fmt = rv_decode_pkg::fmt_b;
			end
			17'b???????_000_1100111: begin
				dec.cls = rv_decode_pkg::cls_jalr;
				dec.fmt = rv_decode_pkg::fmt_i;
			end
			17'b???????_???_1101111: begin
				dec.cls = rv_decode_pkg::cls_jal;
				dec.fmt = rv_decode_pkg::fmt_j;
			end
			17'b???????_???_0110111: begin
				dec.cls = rv_decode_pkg::cls_lui;
				dec.fmt = rv_decode_pkg::fmt_u;
			end
			17'b???????_???_0010111: begin
				dec.cls = rv_decode_pkg::cls_auipc;
				dec.fmt = rv_decode_pkg::fmt_u;
			end
			17'b0000000_000_1110011: begin
				if (inst == `INST_EBREAK) begin
					dec.cls = rv_decode_pkg::cls_ebreak;
				end
			end
			default: begin
				dec.cls = rv_decode_pkg::cls_illegal;
			end
		endcase
	end

endmodule

/* imm_gen.sv */
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module imm_gen (
	input  logic [`XLEN-1:0]    inst,
	input  rv_decode_pkg::dec_t dec,
	output logic [`XLEN-1:0]    imm
);

	logic sign;

	assign sign = inst[31];

	always_comb begin
		case (dec.fmt)
			rv_decode_pkg::fmt_i: begin
				imm = {{(`XLEN-12){sign}}, inst[31:20]};
			end
			rv_decode_pkg::fmt_u: begin
				imm = {inst[31:12], 12'b0};
			end
			rv_decode_pkg::fmt_s: begin
				imm = {{(`XLEN-12){sign}}, inst[31:25], inst[11:7]};
			end
			rv_decode_pkg::fmt_b: begin
				imm = {{(`XLEN-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			rv_decode_pkg::fmt_j: begin
				imm = {{(`XLEN-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			// six bit shift amount, never sign extended
			rv_decode_pkg::fmt_shamt: begin
				imm = {{(`XLEN-6){1'b0}}, inst[25:20]};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

/* alu_ctrl_dec.sv */
`timescale 1ns/10ps

module alu_ctrl_dec (
	input  rv_decode_pkg::dec_t      dec,
	output rv_decode_pkg::alu_ctrl_t alu_ctrl
);

	rv_decode_pkg::alu_op_e arith_op;

	// register and immediate arithmetic share the funct3 map
	always_comb begin
		case (dec.funct3)
			3'b000: begin
				if (dec.cls == rv_decode_pkg::cls_op_reg && dec.f7_b5) begin
					arith_op = rv_decode_pkg::op_sub;
				end else begin
					arith_op = rv_decode_pkg::op_add;
				end
			end
			3'b001: arith_op = rv_decode_pkg::op_sll;
			3'b010: arith_op = rv_decode_pkg::op_scmp;
			3'b011: arith_op = rv_decode_pkg::op_ucmp;
			3'b100: arith_op = rv_decode_pkg::op_xor;
			3'b101: begin
				arith_op = dec.f7_b5 ? rv_decode_pkg::op_sra : rv_decode_pkg::op_srl;
			end
			3'b110: arith_op = rv_decode_pkg::op_or;
			default: arith_op = rv_decode_pkg::op_and;
		endcase
	end

	always_comb begin
		alu_ctrl.src = rv_decode_pkg::src_reg;
		alu_ctrl.op  = rv_decode_pkg::op_add;
		case (dec.cls)
			rv_decode_pkg::cls_op_reg: begin
				alu_ctrl.op = arith_op;
			end
			rv_decode_pkg::cls_op_imm: begin
				alu_ctrl.src = rv_decode_pkg::src_imm;
				alu_ctrl.op  = arith_op;
			end
			// address add for memory access
			rv_decode_pkg::cls_load, rv_decode_pkg::cls_store: begin
				alu_ctrl.src = rv_decode_pkg::src_imm;
			end
			rv_decode_pkg::cls_branch: begin
				if (dec.cmp_unsigned) begin
					alu_ctrl.op = rv_decode_pkg::op_ucmp;
				end else begin
					alu_ctrl.op = rv_decode_pkg::op_scmp;
				end
			end
			default: begin
				alu_ctrl.src = rv_decode_pkg::src_reg;
			end
		endcase
	end

endmodule

/* lsu_req_gen.sv */
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module lsu_req_gen (
	input  rv_decode_pkg::dec_t     dec,
	input  logic [`XLEN-1:0]        exu_data,
	input  logic [`XLEN-1:0]        gpr_rdata2,
	input  logic [`XLEN-1:0]        mem_rdata,
	output rv_decode_pkg::mem_req_t mem_req,
	output logic [`XLEN-1:0]        load_data
);

	logic [1:0]            lane_ofs;
	logic [`XLEN-1:0]      st_data;
	logic [`WMASK_W-1:0]   st_mask;
	logic [2*`XLEN-1:0]    data_rot;
	logic [2*`WMASK_W-1:0] mask_rot;

	// sw stays in place, sb and sh follow the low address bits
	assign lane_ofs = (dec.funct3[1:0] == 2'b10) ? 2'b00 : exu_data[1:0];

	always_comb begin
		case (dec.funct3[1:0])
			2'b00: begin
				st_data = {{(`XLEN-8){1'b0}}, gpr_rdata2[7:0]};
				st_mask = 4'b0001;
			end
			2'b01: begin
				st_data = {{(`XLEN-16){1'b0}}, gpr_rdata2[15:0]};
				st_mask = 4'b0011;
			end
			default: begin
				st_data = gpr_rdata2;
				st_mask = 4'b1111;
			end
		endcase
	end

	// rotate left, a half at offset 3 wraps into lane 0
	assign data_rot = {st_data, st_data} << {lane_ofs, 3'b000};
	assign mask_rot = {st_mask, st_mask} << lane_ofs;

	always_comb begin
		case (dec.funct3[1:0])
			2'b00: begin
				load_data = dec.unsigned_ld ? {{(`XLEN-8){1'b0}}, mem_rdata[7:0]}
					: {{(`XLEN-8){mem_rdata[7]}}, mem_rdata[7:0]};
			end
			2'b01: begin
				load_data = dec.unsigned_ld ? {{(`XLEN-16){1'b0}}, mem_rdata[15:0]}
					: {{(`XLEN-16){mem_rdata[15]}}, mem_rdata[15:0]};
			end
			default: load_data = mem_rdata;
		endcase
	end

	always_comb begin
		mem_req = '0;
		if (dec.cls == rv_decode_pkg::cls_load) begin
			mem_req.rvalid = 1'b1;
			mem_req.raddr  = exu_data;
			case (dec.funct3[1:0])
				2'b00: mem_req.rsize = rv_decode_pkg::rsize_byte;
				2'b01: mem_req.rsize = rv_decode_pkg::rsize_half;
				default: mem_req.rsize = rv_decode_pkg::rsize_word;
			endcase
		end else if (dec.cls == rv_decode_pkg::cls_store) begin
			mem_req.wen   = 1'b1;
			mem_req.waddr = exu_data;
			mem_req.wdata = data_rot[2*`XLEN-1 -: `XLEN];
			mem_req.wmask = mask_rot[2*`WMASK_W-1 -: `WMASK_W];
		end
	end

endmodule

/* wb_pc_ctrl.sv */
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module wb_pc_ctrl (
	input  logic                    sys_clk,
	input  logic                    arst_n,
	input  rv_decode_pkg::dec_t     dec,
	input  logic [`XLEN-1:0]        imm,
	input  logic [`XLEN-1:0]        pc,
	input  logic [`XLEN-1:0]        gpr_rdata1,
	input  logic [`XLEN-1:0]        exu_data,
	input  logic [`XLEN-1:0]        load_data,
	output logic [`REG_ADDR_W-1:0]  gpr_raddr1,
	output logic [`REG_ADDR_W-1:0]  gpr_raddr2,
	output rv_decode_pkg::gpr_wr_t  gpr_wr,
	output rv_decode_pkg::pc_wr_t   pc_wr,
	output logic                    halted
);

	logic [`XLEN-1:0] pc_plus_imm;
	logic [`XLEN-1:0] link_addr;
	logic [`XLEN-1:0] jalr_tgt;
	logic             is_eq;
	logic             is_lt;
	logic             br_taken;
	logic             uses_rs1;
	logic             uses_rs2;

	assign pc_plus_imm = pc + imm;
	assign link_addr   = pc + `PC_STEP;
	assign jalr_tgt    = (gpr_rdata1 + imm) & ~`XLEN'd1;
	assign is_eq       = (exu_data == `EXU_EQ);
	assign is_lt       = (exu_data == `EXU_LT);
	// funct3 bit 2 selects the less-than test, bit 0 inverts it
	assign br_taken    = (dec.funct3[2] ? is_lt : is_eq) ^ dec.funct3[0];

	assign uses_rs1 = dec.cls inside {rv_decode_pkg::cls_op_imm, rv_decode_pkg::cls_op_reg,
		rv_decode_pkg::cls_load, rv_decode_pkg::cls_store, rv_decode_pkg::cls_branch,
		rv_decode_pkg::cls_jalr};
	assign uses_rs2 = dec.cls inside {rv_decode_pkg::cls_op_reg, rv_decode_pkg::cls_store,
		rv_decode_pkg::cls_branch};

	assign gpr_raddr1 = uses_rs1 ? dec.rs1 : '0;
	assign gpr_raddr2 = uses_rs2 ? dec.rs2 : '0;

	always_comb begin
		gpr_wr       = '0;
		gpr_wr.waddr = dec.rd;
		case (dec.cls)
			rv_decode_pkg::cls_op_imm, rv_decode_pkg::cls_op_reg: begin
				gpr_wr.wen = 1'b1;
				// slt and sltu turn the compare code into 0 or 1
				if (dec.funct3[2:1] == 2'b01) begin
					gpr_wr.wdata = {{(`XLEN-1){1'b0}}, is_lt};
				end else begin
					gpr_wr.wdata = exu_data;
				end
			end
			rv_decode_pkg::cls_load: begin
				gpr_wr.wen   = 1'b1;
				gpr_wr.wdata = load_data;
			end
			rv_decode_pkg::cls_lui: begin
				gpr_wr.wen   = 1'b1;
				gpr_wr.wdata = imm;
			end
			rv_decode_pkg::cls_auipc: begin
				gpr_wr.wen   = 1'b1;
				gpr_wr.wdata = pc_plus_imm;
			end
			rv_decode_pkg::cls_jal, rv_decode_pkg::cls_jalr: begin
				gpr_wr.wen   = 1'b1;
				gpr_wr.wdata = link_addr;
			end
			default: begin
				gpr_wr.waddr = '0;
			end
		endcase
	end

	always_comb begin
		pc_wr = '0;
		case (dec.cls)
			rv_decode_pkg::cls_jal: begin
				pc_wr.wen   = 1'b1;
				pc_wr.wdata = pc_plus_imm;
			end
			rv_decode_pkg::cls_jalr: begin
				pc_wr.wen   = 1'b1;
				pc_wr.wdata = jalr_tgt;
			end
			rv_decode_pkg::cls_branch: begin
				pc_wr.wen   = br_taken;
				pc_wr.wdata = br_taken ? pc_plus_imm : '0;
			end
			default: begin
				pc_wr.wen = 1'b0;
			end
		endcase
	end

	// sticky until the next reset
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			halted <= 1'b0;
		end else if (dec.cls == rv_decode_pkg::cls_ebreak) begin
			halted <= 1'b1;
		end
	end

endmodule

/* idu.sv */
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module idu (
	input  logic                     sys_clk,
	input  logic                     arst_n,
	input  logic [`XLEN-1:0]         inst,
	input  logic [`XLEN-1:0]         pc,
	input  logic [`XLEN-1:0]         gpr_rdata1,
	input  logic [`XLEN-1:0]         gpr_rdata2,
	input  logic [`XLEN-1:0]         exu_data,
	input  logic [`XLEN-1:0]         mem_rdata,
	output logic [`REG_ADDR_W-1:0]   gpr_raddr1,
	output logic [`REG_ADDR_W-1:0]   gpr_raddr2,
	output rv_decode_pkg::gpr_wr_t   gpr_wr,
	output rv_decode_pkg::pc_wr_t    pc_wr,
	output logic [`XLEN-1:0]         imm,
	output rv_decode_pkg::alu_ctrl_t alu_ctrl,
	output rv_decode_pkg::mem_req_t  mem_req,
	output logic                     halted
);

	rv_decode_pkg::dec_t dec;
	logic [`XLEN-1:0]    load_data;

	inst_dec u_inst_dec (
		.inst (inst),
		.dec  (dec)
	);

	imm_gen u_imm_gen (
		.inst (inst),
		.dec  (dec),
		.imm  (imm)
	);

	alu_ctrl_dec u_alu_ctrl_dec (
		.dec      (dec),
		.alu_ctrl (alu_ctrl)
	);

	lsu_req_gen u_lsu_req_gen (
		.dec        (dec),
		.exu_data   (exu_data),
		.gpr_rdata2 (gpr_rdata2),
		.mem_rdata  (mem_rdata),
		.mem_req    (mem_req),
		.load_data  (load_data)
	);

	wb_pc_ctrl u_wb_pc_ctrl (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.dec        (dec),
		.imm        (imm),
		.pc         (pc),
		.gpr_rdata1 (gpr_rdata1),
		.exu_data   (exu_data),
		.load_data  (load_data),
		.gpr_raddr1 (gpr_raddr1),
		.gpr_raddr2 (gpr_raddr2),
		.gpr_wr     (gpr_wr),
		.pc_wr      (pc_wr),
		.halted     (halted)
	);

endmodule

/* idu_tb.sv */
`timescale 1ns/10ps
`include "rv_decode_defs.svh"

module idu_tb;

	localparam int CLK_HALF   = 20;
	localparam int RST_CYCLES = 16;
	localparam int ARITH_REPS = 4;
	localparam int UPPER_REPS = 8;
	localparam int JUMP_REPS  = 4;
	localparam int BR_REPS    = 2;
	localparam int LOAD_REPS  = 4;
	// every vector of every test, both reset phases and the halt sequence
	localparam int N_VEC = 19 * ARITH_REPS + 2 * UPPER_REPS + 2 * JUMP_REPS + 18 * BR_REPS
		+ 12 + 5 * LOAD_REPS + 5 + 2 * RST_CYCLES + 12;
	localparam int WATCHDOG_NS = (N_VEC + 50) * 2 * CLK_HALF;

	localparam logic [2:0] BRANCH_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
	localparam logic [2:0] LOAD_F3 [5]   = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};

	logic                     sys_clk;
	logic                     arst_n;
	logic [`XLEN-1:0]         inst;
	logic [`XLEN-1:0]         pc;
	logic [`XLEN-1:0]         gpr_rdata1;
	logic [`XLEN-1:0]         gpr_rdata2;
	logic [`XLEN-1:0]         exu_data;
	logic [`XLEN-1:0]         mem_rdata;
	logic [`REG_ADDR_W-1:0]   gpr_raddr1;
	logic [`REG_ADDR_W-1:0]   gpr_raddr2;
	rv_decode_pkg::gpr_wr_t   gpr_wr;
	rv_decode_pkg::pc_wr_t    pc_wr;
	logic [`XLEN-1:0]         imm;
	rv_decode_pkg::alu_ctrl_t alu_ctrl;
	rv_decode_pkg::mem_req_t  mem_req;
	logic                     halted;

	// model outputs for the vector on the inputs
	logic [`REG_ADDR_W-1:0]   exp_raddr1;
	logic [`REG_ADDR_W-1:0]   exp_raddr2;
	rv_decode_pkg::gpr_wr_t   exp_gpr_wr;
	rv_decode_pkg::pc_wr_t    exp_pc_wr;
	logic [`XLEN-1:0]         exp_imm;
	rv_decode_pkg::alu_ctrl_t exp_alu;
	rv_decode_pkg::mem_req_t  exp_mem;
	logic                     exp_halted;
	logic                     chk_en;

	idu dut (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.inst       (inst),
		.pc         (pc),
		.gpr_rdata1 (gpr_rdata1),
		.gpr_rdata2 (gpr_rdata2),
		.exu_data   (exu_data),
		.mem_rdata  (mem_rdata),
		.gpr_raddr1 (gpr_raddr1),
		.gpr_raddr2 (gpr_raddr2),
		.gpr_wr     (gpr_wr),
		.pc_wr      (pc_wr),
		.imm        (imm),
		.alu_ctrl   (alu_ctrl),
		.mem_req    (mem_req),
		.halted     (halted)
	);

	always #(CLK_HALF) sys_clk = ~sys_clk;

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm12, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm12, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm12, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm13, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm21, input logic [4:0] rd);
		return {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, 7'b1101111};
	endfunction

	// RV32I funct3 table where alt is funct7 bit 5
	function automatic rv_decode_pkg::alu_op_e expected_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0: return alt ? rv_decode_pkg::op_sub : rv_decode_pkg::op_add;
			3'd1: return rv_decode_pkg::op_sll;
			3'd2: return rv_decode_pkg::op_scmp;
			3'd3: return rv_decode_pkg::op_ucmp;
			3'd4: return rv_decode_pkg::op_xor;
			3'd5: return alt ? rv_decode_pkg::op_sra : rv_decode_pkg::op_srl;
			3'd6: return rv_decode_pkg::op_or;
			default: return rv_decode_pkg::op_and;
		endcase
	endfunction

	task automatic mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		$display("Simulation failed");
		$fatal(1, "wrong value on %s", name);
	endtask

	always @(negedge sys_clk) begin
		if (chk_en) begin
			assert (gpr_raddr1 === exp_raddr1)
				else mismatch("gpr_raddr1", 128'(gpr_raddr1), 128'(exp_raddr1));
			assert (gpr_raddr2 === exp_raddr2)
				else mismatch("gpr_raddr2", 128'(gpr_raddr2), 128'(exp_raddr2));
			assert (imm === exp_imm) else mismatch("imm", 128'(imm), 128'(exp_imm));
			assert (alu_ctrl === exp_alu)
				else mismatch("alu_ctrl", 128'(alu_ctrl), 128'(exp_alu));
			assert (gpr_wr === exp_gpr_wr)
				else mismatch("gpr_wr", 128'(gpr_wr), 128'(exp_gpr_wr));
			assert (pc_wr === exp_pc_wr) else mismatch("pc_wr", 128'(pc_wr), 128'(exp_pc_wr));
			assert (mem_req === exp_mem) else mismatch("mem_req", 128'(mem_req), 128'(exp_mem));
			assert (halted === exp_halted)
				else mismatch("halted", 128'(halted), 128'(exp_halted));
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before all tests finished", WATCHDOG_NS);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	task automatic next_cycle();
		@(posedge sys_clk);
		#2;
	endtask

	task automatic clear_expect();
		exp_raddr1 = '0;
		exp_raddr2 = '0;
		exp_imm    = '0;
		exp_alu    = '0;
		exp_gpr_wr = '0;
		exp_pc_wr  = '0;
		exp_mem    = '0;
	endtask

	task automatic random_operands();
		pc         = $urandom();
		gpr_rdata1 = $urandom();
		gpr_rdata2 = $urandom();
		exu_data   = $urandom();
		mem_rdata  = $urandom();
	endtask

	task automatic arith_vector(input logic is_reg, input logic [2:0] f3, input logic alt,
		input logic lt_code);
		logic [31:0] rw;
		logic [11:0] imm12;
		logic [6:0]  f7;
		logic        is_shift;
		next_cycle();
		rw       = $urandom();
		f7       = alt ? 7'b0100000 : 7'b0000000;
		is_shift = !is_reg && (f3 == 3'b001 || f3 == 3'b101);
		imm12    = is_shift ? {f7, rw[19:15]} : rw[31:20];
		random_operands();
		if (lt_code) begin
			exu_data = `EXU_LT;
		end
		if (is_reg) begin
			inst = r_type(f7, rw[14:10], rw[9:5], f3, rw[4:0], 7'b0110011);
		end else begin
			inst = i_type(imm12, rw[9:5], f3, rw[4:0], 7'b0010011);
		end
		clear_expect();
		exp_raddr1 = rw[9:5];
		exp_raddr2 = is_reg ? rw[14:10] : 5'd0;
		if (is_shift) begin
			exp_imm = {27'b0, rw[19:15]};
		end else if (!is_reg) begin
			exp_imm = {{20{imm12[11]}}, imm12};
		end
		exp_alu.src      = is_reg ? rv_decode_pkg::src_reg : rv_decode_pkg::src_imm;
		exp_alu.op       = expected_op(f3, alt);
		exp_gpr_wr.wen   = 1'b1;
		exp_gpr_wr.waddr = rw[4:0];
		// slt family writes a boolean
		if (f3 == 3'b010 || f3 == 3'b011) begin
			exp_gpr_wr.wdata = {31'b0, exu_data == `EXU_LT};
		end else begin
			exp_gpr_wr.wdata = exu_data;
		end
	endtask

	task automatic arith_tests();
		for (int is_reg = 0; is_reg < 2; is_reg++) begin
			for (int f = 0; f < 8; f++) begin
				for (int alt = 0; alt < 2; alt++) begin
					// alt form exists for sub and the arithmetic right shifts
					if (alt == 0 || f == 5 || (is_reg == 1 && f == 0)) begin
						for (int r = 0; r < ARITH_REPS; r++) begin
							arith_vector(is_reg[0], f[2:0], alt[0], r[0] == 1'b0);
						end
					end
				end
			end
		end
	endtask

	task automatic upper_vector(input logic is_auipc);
		logic [31:0] rw;
		next_cycle();
		rw = $urandom();
		random_operands();
		inst = {rw[31:12], rw[11:7], is_auipc ? 7'b0010111 : 7'b0110111};
		clear_expect();
		exp_imm          = {rw[31:12], 12'b0};
		exp_gpr_wr.wen   = 1'b1;
		exp_gpr_wr.waddr = rw[11:7];
		exp_gpr_wr.wdata = is_auipc ? pc + exp_imm : exp_imm;
	endtask

	task automatic jump_vector(input logic is_jalr, input logic [1:0] exu_sel);
		logic [31:0] rw;
		logic [20:0] imm21;
		next_cycle();
		rw    = $urandom();
		imm21 = {rw[31:12], 1'b0};
		random_operands();
		// jumps ignore the compare code
		if (exu_sel == 2'd0) begin
			exu_data = `EXU_EQ;
		end else if (exu_sel == 2'd1) begin
			exu_data = `EXU_LT;
		end
		clear_expect();
		if (is_jalr) begin
			inst            = i_type(rw[31:20], rw[19:15], 3'b000, rw[11:7], 7'b1100111);
			exp_raddr1      = rw[19:15];
			exp_imm         = {{20{rw[31]}}, rw[31:20]};
			exp_pc_wr.wdata = (gpr_rdata1 + exp_imm) & 32'hffff_fffe;
		end else begin
			inst            = j_type(imm21, rw[11:7]);
			exp_imm         = {{11{imm21[20]}}, imm21};
			exp_pc_wr.wdata = pc + exp_imm;
		end
		exp_pc_wr.wen    = 1'b1;
		exp_gpr_wr.wen   = 1'b1;
		exp_gpr_wr.waddr = rw[11:7];
		exp_gpr_wr.wdata = pc + `PC_STEP;
	endtask

	task automatic branch_vector(input logic [2:0] f3, input logic [1:0] exu_sel);
		logic [31:0] rw;
		logic [12:0] imm13;
		logic        taken;
		next_cycle();
		rw    = $urandom();
		imm13 = {rw[31:20], 1'b0};
		random_operands();
		if (exu_sel == 2'd0) begin
			exu_data = `EXU_EQ;
		end else if (exu_sel == 2'd1) begin
			exu_data = `EXU_LT;
		end
		inst = b_type(imm13, rw[14:10], rw[19:15], f3);
		clear_expect();
		exp_raddr1 = rw[19:15];
		exp_raddr2 = rw[14:10];
		exp_imm    = {{19{imm13[12]}}, imm13};
		if (f3 == 3'b100 || f3 == 3'b101) begin
			exp_alu.op = rv_decode_pkg::op_scmp;
		end else begin
			exp_alu.op = rv_decode_pkg::op_ucmp;
		end
		case (f3)
			3'b000: taken = (exu_data == `EXU_EQ);
			3'b001: taken = (exu_data != `EXU_EQ);
			3'b100, 3'b110: taken = (exu_data == `EXU_LT);
			default: taken = (exu_data != `EXU_LT);
		endcase
		if (taken) begin
			exp_pc_wr.wen   = 1'b1;
			exp_pc_wr.wdata = pc + exp_imm;
		end
	endtask

	task automatic store_vector(input logic [2:0] f3, input logic [1:0] ofs);
		logic [31:0] rw;
		logic [31:0] data;
		logic [3:0]  mask;
		next_cycle();
		rw = $urandom();
		random_operands();
		exu_data[1:0] = ofs;
		inst = s_type(rw[31:20], rw[14:10], rw[19:15], f3);
		clear_expect();
		exp_raddr1  = rw[19:15];
		exp_raddr2  = rw[14:10];
		exp_imm     = {{20{rw[31]}}, rw[31:20]};
		exp_alu.src = rv_decode_pkg::src_imm;
		case (f3)
			3'b000: begin
				data = {24'b0, gpr_rdata2[7:0]};
				mask = 4'b0001;
			end
			3'b001: begin
				data = {16'b0, gpr_rdata2[15:0]};
				mask = 4'b0011;
			end
			default: begin
				data = gpr_rdata2;
				mask = 4'b1111;
			end
		endcase
		// byte and half rotate into their lanes and sh at offset 3 wraps
		if (f3 != 3'b010) begin
			data = (data << (8 * ofs)) | (data >> (32 - 8 * ofs));
			mask = (mask << ofs) | (mask >> (4 - ofs));
		end
		exp_mem.wen   = 1'b1;
		exp_mem.waddr = exu_data;
		exp_mem.wdata = data;
		exp_mem.wmask = mask;
	endtask

	task automatic load_vector(input logic [2:0] f3);
		logic [31:0] rw;
		logic [31:0] value;
		next_cycle();
		rw = $urandom();
		random_operands();
		inst = i_type(rw[31:20], rw[19:15], f3, rw[11:7], 7'b0000011);
		clear_expect();
		exp_raddr1     = rw[19:15];
		exp_imm        = {{20{rw[31]}}, rw[31:20]};
		exp_alu.src    = rv_decode_pkg::src_imm;
		exp_mem.rvalid = 1'b1;
		exp_mem.raddr  = exu_data;
		case (f3)
			3'b000: begin
				value         = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
				exp_mem.rsize = rv_decode_pkg::rsize_byte;
			end
			3'b001: begin
				value         = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
				exp_mem.rsize = rv_decode_pkg::rsize_half;
			end
			3'b100: begin
				value         = {24'b0, mem_rdata[7:0]};
				exp_mem.rsize = rv_decode_pkg::rsize_byte;
			end
			3'b101: begin
				value         = {16'b0, mem_rdata[15:0]};
				exp_mem.rsize = rv_decode_pkg::rsize_half;
			end
			default: begin
				value         = mem_rdata;
				exp_mem.rsize = rv_decode_pkg::rsize_word;
			end
		endcase
		exp_gpr_wr.wen   = 1'b1;
		exp_gpr_wr.waddr = rw[11:7];
		exp_gpr_wr.wdata = value;
	endtask

	// no strobes, no immediate, default execute control
	task automatic illegal_vector(input logic [31:0] word);
		next_cycle();
		random_operands();
		inst = word;
		clear_expect();
	endtask

	task automatic halt_tests();
		next_cycle();
		random_operands();
		inst = `INST_EBREAK;
		clear_expect();
		for (int i = 0; i < 4; i++) begin
			arith_vector(i[0], 3'b000, 1'b0, 1'b0);
			exp_halted = 1'b1;
		end
		next_cycle();
		arst_n = 1'b0;
		inst   = `INST_EBREAK;
		clear_expect();
		exp_halted = 1'b0;
		repeat (RST_CYCLES) next_cycle();
		inst = '0;
		next_cycle();
		arst_n = 1'b1;
		arith_vector(1'b0, 3'b100, 1'b0, 1'b0);
		arith_vector(1'b1, 3'b110, 1'b0, 1'b0);
	endtask

	initial begin
		void'($urandom(58));
		sys_clk    = 1'b0;
		arst_n     = 1'b0;
		inst       = '0;
		pc         = '0;
		gpr_rdata1 = '0;
		gpr_rdata2 = '0;
		exu_data   = '0;
		mem_rdata  = '0;
		chk_en     = 1'b0;
		exp_halted = 1'b0;
		clear_expect();
		repeat (RST_CYCLES) @(posedge sys_clk);
		#2;
		arst_n = 1'b1;
		chk_en = 1'b1;

		arith_tests();
		for (int r = 0; r < UPPER_REPS; r++) begin
			upper_vector(1'b0);
			upper_vector(1'b1);
		end
		for (int r = 0; r < JUMP_REPS; r++) begin
			jump_vector(1'b0, 2'(r % 3));
			jump_vector(1'b1, 2'(r % 3));
		end
		for (int b = 0; b < 6; b++) begin
			for (int e = 0; e < 3; e++) begin
				for (int r = 0; r < BR_REPS; r++) begin
					branch_vector(BRANCH_F3[b], e[1:0]);
				end
			end
		end
		for (int f = 0; f < 3; f++) begin
			for (int ofs = 0; ofs < 4; ofs++) begin
				store_vector(f[2:0], ofs[1:0]);
			end
		end
		for (int l = 0; l < 5; l++) begin
			for (int r = 0; r < LOAD_REPS; r++) begin
				load_vector(LOAD_F3[l]);
			end
		end
		illegal_vector(32'h0000_0000);
		illegal_vector(32'hffff_ffff);
		// ecall, ld and mul are outside the decoded set
		illegal_vector(32'h0000_0073);
		illegal_vector(i_type(12'h010, 5'd2, 3'b011, 5'd3, 7'b0000011));
		illegal_vector(r_type(7'b0000001, 5'd4, 5'd5, 3'b000, 5'd6, 7'b0110011));
		halt_tests();

		next_cycle();
		chk_en = 1'b0;
		$display("Simulation passed");
		$finish;
	end

endmodule

/* idu.f */
+incdir+.
rv_decode_pkg.sv
inst_dec.sv
imm_gen.sv
alu_ctrl_dec.sv
lsu_req_gen.sv
wb_pc_ctrl.sv
idu.sv
idu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the idu testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module idu_tb -f idu.f \
	&& ./obj_dir/Vidu_tb | tee /dev/stderr | grep -q "Simulation passed" \
	&& echo "idu: run passed" \
	|| { echo "idu: run FAILED"; exit 1; }
